//--- boot_rom.sv
module boot_rom #(
	parameter int DEPTH = 64
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               cs_i,
	input  soc_bus_pkg::addr_t adr_i,
	output soc_bus_pkg::data_t dat_o,
	output logic               rdy_o
);
	import soc_bus_pkg::*;

	localparam int AW = $clog2(DEPTH);

	data_t mem [DEPTH];
	logic  cs_q;
	logic  first;

	// Upper half signature plus index, lower half its inverse.
	initial begin
		$readmemh("rom_init.hex", mem);
	end

	assign first = cs_i & ~cs_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cs_q  <= 1'b0;
			rdy_o <= 1'b0;
		end else begin
			cs_q  <= cs_i;
			rdy_o <= first;  // One pulse per select.
		end
	end

	always_ff @(posedge clk) begin
		if (first)
			dat_o <= mem[adr_i[AW+2:3]];
	end

endmodule

//--- bus_ctrl.sv
module bus_ctrl (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  soc_bus_pkg::sel_t  sel_i,
	input  soc_bus_pkg::addr_t adr_i,
	input  soc_bus_pkg::data_t dat_i,
	input  soc_bus_pkg::data_t ram_dat_i,
	input  soc_bus_pkg::data_t rom_dat_i,
	input  soc_bus_pkg::half_t text_dat_i,
	input  logic               rom_rdy_i,
	input  logic               text_rdy_i,
	output logic               ram_cs_o,
	output logic               rom_cs_o,
	output logic               text_cs_o,
	output logic               ack_o,
	output logic               err_o,
	output soc_bus_pkg::data_t dat_o,
	output logic [7:0]         led_o
);
	import soc_bus_pkg::*;

	logic    req;
	logic    pend_q;
	logic    first;
	logic    led_ack_q;
	region_e region;

	assign req   = cyc_i & stb_i;
	assign first = req & ~pend_q;  // First cycle of a request.

	always_comb begin
		region = REG_NONE;
		if (req) begin
			if (adr_i[31:16] == RAM_BASE_HI)
				region = REG_RAM;
			else if (adr_i[31:16] == ROM_BASE_HI)
				region = REG_ROM;
			else if (adr_i[31:16] == TEXT_MEM_HI || adr_i[31:16] == TEXT_REG_HI)
				region = REG_TEXT;
			else if (adr_i[31:8] == LED_BASE_HI)
				region = REG_LED;
		end
	end

	assign ram_cs_o  = req & (region == REG_RAM);
	assign rom_cs_o  = req & (region == REG_ROM);
	assign text_cs_o = req & (region == REG_TEXT);

	// RAM answers in the request cycle, the rest one cycle later.
	assign ack_o = ram_cs_o | rom_rdy_i | text_rdy_i | led_ack_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pend_q    <= 1'b0;
			led_ack_q <= 1'b0;
			err_o     <= 1'b0;
			led_o     <= '0;
		end else begin
			pend_q    <= req;  // Held until stb drops.
			led_ack_q <= first & (region == REG_LED);
			err_o     <= first & (region == REG_NONE);
			if (first && region == REG_LED && we_i && sel_i[0])
				led_o <= dat_i[7:0];
		end
	end

	always_comb begin
		case (region)
			REG_RAM:  dat_o = ram_dat_i;
			REG_ROM:  dat_o = rom_dat_i;
			REG_TEXT: dat_o = {2{text_dat_i}};  // Same word on both halves.
			REG_LED:  dat_o = {{(DATA_W-8){1'b0}}, led_o};
			default:  dat_o = '0;
		endcase
	end

endmodule

//--- byte_lane_ram.sv
module byte_lane_ram #(
	parameter type word_t = soc_bus_pkg::data_t,
	parameter int  DEPTH  = 2048
) (
	input  logic                           clk,
	input  logic                           cs_i,
	input  logic                           we_i,
	input  logic [$bits(word_t)/8-1:0]     be_i,
	input  logic [$clog2(DEPTH)-1:0]       addr_i,
	input  word_t                          wdata_i,
	output word_t                          rdata_o
);

	localparam int NBYTES = $bits(word_t) / 8;

	word_t mem [DEPTH];

	// Each enabled byte lane is written on its own.
	always_ff @(posedge clk) begin
		if (cs_i && we_i) begin
			for (int b = 0; b < NBYTES; b++) begin
				if (be_i[b])
					mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
		end
	end

	assign rdata_o = mem[addr_i];  // Asynchronous read.

endmodule

//--- list.f
soc_bus_pkg.sv
bus_ctrl.sv
byte_lane_ram.sv
boot_rom.sv
text_ctrl.sv
soc_bus_top.sv
soc_bus_tb.sv

//--- rom_init.hex
B00700004FF8FFFF
B00700014FF8FFFE
B00700024FF8FFFD
B00700034FF8FFFC
B00700044FF8FFFB
B00700054FF8FFFA
B00700064FF8FFF9
B00700074FF8FFF8
B00700084FF8FFF7
B00700094FF8FFF6
B007000A4FF8FFF5
B007000B4FF8FFF4
B007000C4FF8FFF3
B007000D4FF8FFF2
B007000E4FF8FFF1
B007000F4FF8FFF0
B00700104FF8FFEF
B00700114FF8FFEE
B00700124FF8FFED
B00700134FF8FFEC
B00700144FF8FFEB
B00700154FF8FFEA
B00700164FF8FFE9
B00700174FF8FFE8
B00700184FF8FFE7
B00700194FF8FFE6
B007001A4FF8FFE5
B007001B4FF8FFE4
B007001C4FF8FFE3
B007001D4FF8FFE2
B007001E4FF8FFE1
B007001F4FF8FFE0
B00700204FF8FFDF
B00700214FF8FFDE
B00700224FF8FFDD
B00700234FF8FFDC
B00700244FF8FFDB
B00700254FF8FFDA
B00700264FF8FFD9
B00700274FF8FFD8
B00700284FF8FFD7
B00700294FF8FFD6
B007002A4FF8FFD5
B007002B4FF8FFD4
B007002C4FF8FFD3
B007002D4FF8FFD2
B007002E4FF8FFD1
B007002F4FF8FFD0
B00700304FF8FFCF
B00700314FF8FFCE
B00700324FF8FFCD
B00700334FF8FFCC
B00700344FF8FFCB
B00700354FF8FFCA
B00700364FF8FFC9
B00700374FF8FFC8
B00700384FF8FFC7
B00700394FF8FFC6
B007003A4FF8FFC5
B007003B4FF8FFC4
B007003C4FF8FFC3
B007003D4FF8FFC2
B007003E4FF8FFC1
B007003F4FF8FFC0

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module soc_bus_tb -f list.f -o soc_bus_sim \
	&& ./obj_dir/soc_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

//--- soc_bus_pkg.sv
package soc_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int HALF_W = 32;
	localparam int SEL_W  = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [HALF_W-1:0] half_t;
	typedef logic [SEL_W-1:0]  sel_t;

	typedef enum logic [2:0] {
		REG_RAM,
		REG_ROM,
		REG_TEXT,
		REG_LED,
		REG_NONE
	} region_e;

	// Upper address bits of each region.
	localparam logic [15:0] RAM_BASE_HI = 16'h0000;
	localparam logic [15:0] ROM_BASE_HI = 16'h0001;
	localparam logic [15:0] TEXT_MEM_HI = 16'hFFD0;  // Character memory.
	localparam logic [15:0] TEXT_REG_HI = 16'hFFDA;  // Cursor and colour.
	localparam logic [23:0] LED_BASE_HI = 24'hFFDC06;

	// Word n of the ROM holds this plus n in its upper half.
	localparam logic [31:0] ROM_SIGNATURE = 32'hB007_0000;

endpackage

//--- soc_bus_tb.sv
module soc_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import soc_bus_pkg::*;

	localparam logic [1:0] RESP_NOW  = 2'd0;  // Ack in the request cycle.
	localparam logic [1:0] RESP_LATE = 2'd1;
	localparam logic [1:0] RESP_ERR  = 2'd2;
	localparam logic [1:0] CHK_NONE  = 2'd0;
	localparam logic [1:0] CHK_DATA  = 2'd1;
	localparam logic [1:0] CHK_HALF  = 2'd2;  // Text word on both halves.
	localparam addr_t CURSOR_ADR = {TEXT_REG_HI, 16'h0000};
	localparam addr_t COLOR_ADR  = {TEXT_REG_HI, 16'h0004};
	localparam addr_t LED_ADR    = {LED_BASE_HI, 8'h00};
	localparam addr_t UNMAPPED   = 32'h8000_0000;

	typedef struct packed {
		logic       we;
		addr_t      adr;
		sel_t       sel;
		data_t      dat;
		logic [1:0] resp;
		logic [1:0] chk;
		data_t      exp;
		logic [7:0] led_exp;
		half_t      cursor_exp;
	} entry_t;

	logic        clk, rst_n_i, cyc_i, stb_i, we_i, ack_o, err_o;
	sel_t        sel_i;
	addr_t       adr_i;
	data_t       dat_i, dat_o;
	logic [7:0]  led_o;
	logic [10:0] cursor_o;

	entry_t      table_q[$];
	data_t       ram_model [4];
	half_t       text_model [4];
	logic [7:0]  led_model = '0;
	half_t       cursor_model = '0;
	half_t       color_model = '0;
	logic [31:0] rng_state = 32'd49;
	int          cur_entry = -1;
	int          cycle_cnt = 0;
	int          cycle_limit = 1000;

	soc_bus_top #(
		.RAM_WORDS (2048),
		.ROM_WORDS (64),
		.TEXT_WORDS(2048)
	) dut (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic data_t byte_mask(input sel_t sel);
		data_t m;
		for (int b = 0; b < 8; b++)
			m[b*8 +: 8] = {8{sel[b]}};
		return m;
	endfunction

	function automatic void push_entry(input logic we, input addr_t adr, input sel_t sel,
		input data_t dat, input logic [1:0] resp, input logic [1:0] chk, input data_t exp);
		entry_t e;
		e = '{we, adr, sel, dat, resp, chk, exp, led_model, cursor_model};
		table_q.push_back(e);
	endfunction

	function automatic void ram_access(input logic we, input int idx, input sel_t sel,
		input data_t dat);
		if (we)
			ram_model[idx] = (ram_model[idx] & ~byte_mask(sel)) | (dat & byte_mask(sel));
		push_entry(we, {RAM_BASE_HI, 13'(idx), 3'b000}, sel, dat, RESP_NOW,
			we ? CHK_NONE : CHK_DATA, ram_model[idx]);
	endfunction

	function automatic void rom_access(input logic we, input int n);
		half_t hi;
		hi = ROM_SIGNATURE + 32'(n);
		push_entry(we, {ROM_BASE_HI, 13'(n), 3'b000}, 8'hFF, {xorshift32(), xorshift32()},
			RESP_LATE, we ? CHK_NONE : CHK_DATA, {hi, ~hi});
	endfunction

	function automatic void text_access(input logic we, input int idx, input sel_t sel,
		input data_t dat);
		data_t m;
		m = byte_mask(sel);
		if (we && idx % 2 == 1)  // Odd words use the upper lane.
			text_model[idx] = (text_model[idx] & ~m[63:32]) | (dat[63:32] & m[63:32]);
		else if (we)
			text_model[idx] = (text_model[idx] & ~m[31:0]) | (dat[31:0] & m[31:0]);
		push_entry(we, {TEXT_MEM_HI, 14'(idx), 2'b00}, sel, dat, RESP_LATE,
			we ? CHK_NONE : CHK_HALF, {2{text_model[idx]}});
	endfunction

	function automatic void build_table();
		data_t d;
		// Full writes first, so partial writes merge with known bytes.
		for (int i = 0; i < 4; i++)
			ram_access(1'b1, i, 8'hFF, {xorshift32(), xorshift32()});
		for (int k = 0; k < 6; k++) begin
			d = {xorshift32(), xorshift32()};
			ram_access(1'b1, k % 4, (d[7:0] & 8'h7E) | 8'h01, {xorshift32(), xorshift32()});
		end
		for (int i = 0; i < 4; i++)
			ram_access(1'b0, i, 8'hFF, '0);
		rom_access(1'b0, 0);
		rom_access(1'b0, 1);
		rom_access(1'b0, 17);
		rom_access(1'b0, 42);
		rom_access(1'b0, 63);
		rom_access(1'b1, 5);
		rom_access(1'b0, 5);
		for (int i = 0; i < 4; i++)
			text_access(1'b1, i, 8'hFF, {xorshift32(), xorshift32()});
		for (int k = 0; k < 4; k++) begin
			d = {xorshift32(), xorshift32()};
			text_access(1'b1, k, d[7:0] | 8'h11, {xorshift32(), xorshift32()});
		end
		for (int i = 0; i < 4; i++)
			text_access(1'b0, i, 8'hFF, '0);
		push_entry(1'b0, CURSOR_ADR, 8'hFF, '0, RESP_LATE, CHK_HALF, '0);
		push_entry(1'b0, COLOR_ADR, 8'hFF, '0, RESP_LATE, CHK_HALF, '0);
		cursor_model = 32'hFFFF_F5A3 & 32'h0000_07FF;  // Only 11 bits kept.
		push_entry(1'b1, CURSOR_ADR, 8'h0F, 64'hFFFF_F5A3, RESP_LATE, CHK_NONE, '0);
		push_entry(1'b0, CURSOR_ADR, 8'hFF, '0, RESP_LATE, CHK_HALF, {2{cursor_model}});
		d = {xorshift32(), xorshift32()};
		color_model = d[63:32];  // Register 1 sits in the upper lane.
		push_entry(1'b1, COLOR_ADR, 8'hF0, d, RESP_LATE, CHK_NONE, '0);
		push_entry(1'b0, COLOR_ADR, 8'hFF, '0, RESP_LATE, CHK_HALF, {2{color_model}});
		push_entry(1'b0, LED_ADR, 8'hFF, '0, RESP_LATE, CHK_DATA, '0);
		d = {xorshift32(), xorshift32()};
		led_model = d[7:0];
		push_entry(1'b1, LED_ADR, 8'h01, d, RESP_LATE, CHK_NONE, '0);
		push_entry(1'b1, LED_ADR, 8'hFE, ~d, RESP_LATE, CHK_NONE, '0);
		push_entry(1'b0, LED_ADR, 8'hFF, '0, RESP_LATE, CHK_DATA, {56'd0, led_model});
		push_entry(1'b0, UNMAPPED, 8'hFF, '0, RESP_ERR, CHK_DATA, '0);
		push_entry(1'b1, UNMAPPED, 8'hFF, d, RESP_ERR, CHK_NONE, '0);
		ram_access(1'b0, 2, 8'hFF, '0);
	endfunction

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: entry %0d %s is %h, expected %h",
				$time, cur_entry, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_half(input string what, input half_t got, input half_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: entry %0d %s is %h, expected %h",
				$time, cur_entry, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "half word mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: entry %0d %s is %b, expected %b",
				$time, cur_entry, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic run_entry(input entry_t e);
		int wait_n;
		@(posedge clk);
		#2;
		cyc_i  = 1'b1;
		stb_i  = 1'b1;
		we_i   = e.we;
		sel_i  = e.sel;
		adr_i  = e.adr;
		dat_i  = e.dat;
		wait_n = 0;
		@(negedge clk);
		while (!ack_o && !err_o && wait_n < 4) begin
			wait_n++;
			@(negedge clk);
		end
		if (wait_n == 4) begin
			$display("The DUT gave neither ack nor err for entry %0d.", cur_entry);
			$display("RESULT: FAIL");
			$fatal(1, "no response");
		end
		check_flag("ack_o", ack_o, e.resp != RESP_ERR);
		check_flag("err_o", err_o, e.resp == RESP_ERR);
		check_flag("zero-wait ack", wait_n == 0, e.resp == RESP_NOW);
		check_flag("one-cycle delay", wait_n == 1, e.resp != RESP_NOW);
		if (e.chk == CHK_DATA)
			check_data("dat_o", dat_o, e.exp);
		if (e.chk == CHK_HALF) begin
			check_half("dat_o low half", dat_o[31:0], e.exp[31:0]);
			check_half("dat_o high half", dat_o[63:32], e.exp[63:32]);
		end
		@(posedge clk);
		#2;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		@(negedge clk);
		check_flag("ack_o after release", ack_o, 1'b0);
		check_flag("err_o after release", err_o, 1'b0);
		check_half("led_o", {24'd0, led_o}, {24'd0, e.led_exp});
		check_half("cursor_o", {21'd0, cursor_o}, e.cursor_exp);
	endtask

	initial begin
		clk     = 1'b0;
		rst_n_i = 1'b0;
		cyc_i   = 1'b0;
		stb_i   = 1'b0;
		we_i    = 1'b0;
		sel_i   = '0;
		adr_i   = '0;
		dat_i   = '0;
		build_table();
		cycle_limit = table_q.size() * 8 + 100;
		repeat (16) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		@(negedge clk);
		check_flag("ack_o after reset", ack_o, 1'b0);
		check_flag("err_o after reset", err_o, 1'b0);
		foreach (table_q[i]) begin
			cur_entry = i;
			run_entry(table_q[i]);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- soc_bus_top.sv
module soc_bus_top #(
	parameter int RAM_WORDS  = 2048,
	parameter int ROM_WORDS  = 64,
	parameter int TEXT_WORDS = 2048
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  soc_bus_pkg::sel_t  sel_i,
	input  soc_bus_pkg::addr_t adr_i,
	input  soc_bus_pkg::data_t dat_i,
	output soc_bus_pkg::data_t dat_o,
	output logic               ack_o,
	output logic               err_o,
	output logic [7:0]         led_o,
	output logic [10:0]        cursor_o
);
	import soc_bus_pkg::*;

	localparam int RAM_AW = $clog2(RAM_WORDS);

	logic  ram_cs;
	logic  rom_cs;
	logic  text_cs;
	logic  rom_rdy;
	logic  text_rdy;
	data_t ram_dat;
	data_t rom_dat;
	half_t text_dat;

	bus_ctrl u_ctrl (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.sel_i     (sel_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.ram_dat_i (ram_dat),
		.rom_dat_i (rom_dat),
		.text_dat_i(text_dat),
		.rom_rdy_i (rom_rdy),
		.text_rdy_i(text_rdy),
		.ram_cs_o  (ram_cs),
		.rom_cs_o  (rom_cs),
		.text_cs_o (text_cs),
		.ack_o     (ack_o),
		.err_o     (err_o),
		.dat_o     (dat_o),
		.led_o     (led_o)
	);

	byte_lane_ram #(
		.word_t(data_t),
		.DEPTH (RAM_WORDS)
	) main_ram (
		.clk    (clk),
		.cs_i   (ram_cs),
		.we_i   (we_i),
		.be_i   (sel_i),
		.addr_i (adr_i[RAM_AW+2:3]),  // 64-bit word index.
		.wdata_i(dat_i),
		.rdata_o(ram_dat)
	);

	boot_rom #(
		.DEPTH(ROM_WORDS)
	) u_rom (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.cs_i   (rom_cs),
		.adr_i  (adr_i),
		.dat_o  (rom_dat),
		.rdy_o  (rom_rdy)
	);

	text_ctrl #(
		.DEPTH(TEXT_WORDS)
	) u_text (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.cs_i    (text_cs),
		.we_i    (we_i),
		.sel_i   (sel_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.dat_o   (text_dat),
		.rdy_o   (text_rdy),
		.cursor_o(cursor_o)
	);

endmodule

//--- text_ctrl.sv
module text_ctrl #(
	parameter int DEPTH = 2048
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               cs_i,
	input  logic               we_i,
	input  soc_bus_pkg::sel_t  sel_i,
	input  soc_bus_pkg::addr_t adr_i,
	input  soc_bus_pkg::data_t dat_i,
	output soc_bus_pkg::half_t dat_o,
	output logic               rdy_o,
	output logic [10:0]        cursor_o
);
	import soc_bus_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic       cs_q;
	logic       first;
	logic       hi_lane;
	logic       mem_hit;
	logic       reg_hit;
	logic [1:0] reg_idx;
	logic [3:0] lane_be;
	half_t      lane_dat;
	half_t      mem_rdata;
	half_t      reg_rdata;
	half_t      color_q;

	assign first    = cs_i & ~cs_q;
	assign hi_lane  = adr_i[2];  // Upper or lower 32-bit lane.
	assign lane_dat = hi_lane ? dat_i[63:32] : dat_i[31:0];
	assign lane_be  = hi_lane ? sel_i[7:4] : sel_i[3:0];
	assign mem_hit  = adr_i[31:16] == TEXT_MEM_HI;
	assign reg_hit  = adr_i[31:16] == TEXT_REG_HI;
	assign reg_idx  = adr_i[3:2];

	byte_lane_ram #(
		.word_t(half_t),
		.DEPTH (DEPTH)
	) char_mem (
		.clk    (clk),
		.cs_i   (first & mem_hit),
		.we_i   (we_i),
		.be_i   (lane_be),
		.addr_i (adr_i[AW+1:2]),
		.wdata_i(lane_dat),
		.rdata_o(mem_rdata)
	);

	always_comb begin
		case (reg_idx)
			2'd0:    reg_rdata = {21'd0, cursor_o};
			2'd1:    reg_rdata = color_q;
			default: reg_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cs_q     <= 1'b0;
			rdy_o    <= 1'b0;
			cursor_o <= '0;
			color_q  <= '0;
		end else begin
			cs_q  <= cs_i;
			rdy_o <= first;
			if (first && reg_hit && we_i && reg_idx == 2'd0) begin
				if (lane_be[0])
					cursor_o[7:0] <= lane_dat[7:0];
				if (lane_be[1])
					cursor_o[10:8] <= lane_dat[10:8];  // Upper bits dropped.
			end
			if (first && reg_hit && we_i && reg_idx == 2'd1) begin
				for (int b = 0; b < 4; b++) begin
					if (lane_be[b])
						color_q[b*8 +: 8] <= lane_dat[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (first)
			dat_o <= mem_hit ? mem_rdata : reg_rdata;
	end

endmodule
